// File: project.f
verilog/mem_map_pkg.sv
verilog/cpu_mem_interface.sv
verilog/main_memory.sv
verilog/loader_memory.sv
verilog/text_display.sv
verilog/cpu_mem_top.sv
verif/cpu_mem_assertions.sv
verif/cpu_mem_tb.sv

// File: Makefile
TOP = cpu_mem_tb

.PHONY: all run check clean

all: check

obj_dir/V$(TOP): project.f $(wildcard verilog/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log

check: run
	@if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: verif/cpu_mem_tb.sv
`timescale 1ns/1ns

module cpu_mem_tb;

    localparam int MAIN_LATENCY = 4;
    localparam int H_ACTIVE     = 16;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 4;
    localparam int H_BACK       = 2;
    localparam int V_ACTIVE     = 8;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 1;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME        = H_TOTAL * V_TOTAL;
    localparam int COLS         = H_ACTIVE >> 3;
    // directed and random accesses take about 400 cycles
    localparam int LIMIT        = 600 + 4 * FRAME;

    logic        pixel_clk = 1'b0;
    logic        rst;
    logic [29:0] instr_addr;
    logic        dmem_read;
    logic        dmem_write;
    logic [29:0] dmem_addr;
    logic [3:0]  dmem_byte_en;
    logic [31:0] data_from_reg;
    logic        mem_stall;
    logic [31:0] dmem_data_out;
    logic [31:0] instr_data_out;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;
    logic        vga_hs;
    logic        vga_vs;

    // reference models
    logic [31:0] main_model [16];
    logic [31:0] loader_model [16];
    logic [7:0]  text_model [4];

    int          errors = 0;
    int          cycles = 0;
    integer      seed = 32'h194883c7;
    logic [7:0]  exp_char;
    logic        pixel_check = 1'b0;
    int          hpos = 0;
    int          vpos = 0;
    logic        pos_ok;
    logic        hs_prev;
    logic        vs_prev;

    cpu_mem_top #(
        .MAIN_DEPTH_LOG2   (6),
        .LOADER_DEPTH_LOG2 (4),
        .MAIN_LATENCY      (MAIN_LATENCY),
        .VMEM_ADDR_WIDTH   (8),
        .H_ACTIVE          (H_ACTIVE),
        .H_FRONT           (H_FRONT),
        .H_SYNC            (H_SYNC),
        .H_BACK            (H_BACK),
        .V_ACTIVE          (V_ACTIVE),
        .V_FRONT           (V_FRONT),
        .V_SYNC            (V_SYNC),
        .V_BACK            (V_BACK)
    ) uut (.*);

    always #10 pixel_clk = ~pixel_clk;

    always @(posedge pixel_clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout after %0d cycles, a test did not finish", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    // one cpu access held until the stall drops
    task automatic mem_access(input logic rd, input logic wr, input logic [29:0] addr,
                              input logic [3:0] be, input logic [31:0] wd,
                              output logic [31:0] rdat, output int stalls);
        stalls = 0;
        @(posedge pixel_clk);
        dmem_read     <= rd;
        dmem_write    <= wr;
        dmem_addr     <= addr;
        dmem_byte_en  <= be;
        data_from_reg <= wd;
        @(negedge pixel_clk);
        while (mem_stall) begin
            stalls++;
            @(negedge pixel_clk);
        end
        rdat = dmem_data_out;
        @(posedge pixel_clk);
        dmem_read  <= 1'b0;
        dmem_write <= 1'b0;
    endtask

    // fetch word shows up one cycle after the address
    task automatic fetch_and_compare(input string name, input logic [29:0] addr,
                                     input logic [31:0] exp);
        @(posedge pixel_clk);
        instr_addr <= addr;
        @(posedge pixel_clk);
        @(negedge pixel_clk);
        compare_word(name, exp, instr_data_out);
    endtask

    always @(negedge pixel_clk) begin
        if (uut.vmem_wen) begin
            compare_word("vmem char", {24'h0, exp_char}, {24'h0, uut.vmem_char});
        end
    end

    ////////////////////
    // raster tracker
    ////////////////////

    // position rebuilt from the sync edges at the outputs
    always @(negedge pixel_clk) begin
        logic [7:0] code;
        if (!rst) begin
            pos_ok  = 1'b0;
            hs_prev = 1'b1;
            vs_prev = 1'b1;
        end else begin
            if (pos_ok) begin
                hpos++;
                if (hpos == H_TOTAL) begin
                    hpos = 0;
                    vpos = (vpos + 1) % V_TOTAL;
                end
            end
            if (hs_prev && !vga_hs) hpos = H_ACTIVE + H_FRONT;
            if (vs_prev && !vga_vs) begin
                hpos   = 0;
                vpos   = V_ACTIVE + V_FRONT;
                pos_ok = 1'b1;
            end
            hs_prev = vga_hs;
            vs_prev = vga_vs;
            if (pos_ok && pixel_check) begin
                if (hpos < H_ACTIVE && vpos < V_ACTIVE) begin
                    code = text_model[(vpos >> 3) * COLS + (hpos >> 3)];
                    compare_word("pixel", {20'h0, code[7:4], code[3:0], code[7:4] ^ code[3:0]},
                                 {20'h0, vga_r, vga_g, vga_b});
                end else begin
                    compare_word("blank pixel", 32'h0, {20'h0, vga_r, vga_g, vga_b});
                end
            end
        end
    end

    initial begin
        logic [31:0] w;
        logic [31:0] rd;
        logic [3:0]  be;
        int          a;
        int          st;
        rst           = 1'b0;
        instr_addr    = '0;
        dmem_read     = 1'b0;
        dmem_write    = 1'b0;
        dmem_addr     = '0;
        dmem_byte_en  = '0;
        data_from_reg = '0;
        exp_char      = '0;
        repeat (8) @(posedge pixel_clk);
        rst <= 1'b1;

        // main memory full words then merged byte writes
        for (int i = 0; i < 16; i++) begin
            w = $random(seed);
            main_model[i] = w;
            mem_access(1'b0, 1'b1, 30'(i), 4'hf, w, rd, st);
            compare_word("main write stall", 0, st);
        end
        for (int n = 0; n < 20; n++) begin
            a  = $random(seed) & 15;
            be = $random(seed);
            w  = $random(seed);
            for (int i = 0; i < 4; i++) begin
                if (be[3-i]) main_model[a][8*i +: 8] = w[8*i +: 8];
            end
            mem_access(1'b0, 1'b1, 30'(a), be, w, rd, st);
            compare_word("main byte write stall", 0, st);
        end
        for (int i = 0; i < 16; i++) begin
            mem_access(1'b1, 1'b0, 30'(i), 4'hf, '0, rd, st);
            compare_word("main read", main_model[i], rd);
            compare_word("main read stall", MAIN_LATENCY, st);
        end
        for (int i = 0; i < 16; i++) begin
            fetch_and_compare("main fetch", 30'(i), main_model[i]);
        end

        // loader data port and fetch port
        for (int i = 0; i < 16; i++) begin
            w = $random(seed);
            loader_model[i] = w;
            mem_access(1'b0, 1'b1, {4'hf, 26'(i)}, 4'hf, w, rd, st);
            compare_word("loader write stall", 0, st);
        end
        for (int i = 0; i < 16; i++) begin
            mem_access(1'b1, 1'b0, {4'hf, 26'(i)}, 4'hf, '0, rd, st);
            compare_word("loader read", loader_model[i], rd);
            compare_word("loader read stall", 1, st);
            fetch_and_compare("loader fetch", {4'hf, 26'(i)}, loader_model[i]);
        end

        // one video write per byte lane
        for (int lane = 0; lane < 4; lane++) begin
            w        = $random(seed);
            exp_char = w[8*lane +: 8];
            text_model[lane] = exp_char;
            mem_access(1'b0, 1'b1, {4'hc, 26'd0}, 4'b1000 >> lane, w, rd, st);
            compare_word("vmem write stall", 3, st);
        end

        // reserved regions read zero and ignore writes
        mem_access(1'b1, 1'b0, {4'hd, 26'd5}, 4'hf, '0, rd, st);
        compare_word("timer read", 0, rd);
        mem_access(1'b1, 1'b0, {4'he, 26'd5}, 4'hf, '0, rd, st);
        compare_word("kbd read", 0, rd);
        mem_access(1'b0, 1'b1, {4'hd, 26'd3}, 4'hf, 32'hdeadbeef, rd, st);
        mem_access(1'b0, 1'b1, {4'he, 26'd3}, 4'hf, 32'hcafef00d, rd, st);
        mem_access(1'b1, 1'b0, 30'd3, 4'hf, '0, rd, st);
        compare_word("main after reserved write", main_model[3], rd);

        // new code at cell 0 then watch two frames
        exp_char      = 8'ha5;
        text_model[0] = 8'ha5;
        mem_access(1'b0, 1'b1, {4'hc, 26'd0}, 4'b1000, 32'h000000a5, rd, st);
        repeat (4) @(posedge pixel_clk);
        pixel_check = 1'b1;
        repeat (2 * FRAME) @(posedge pixel_clk);
        pixel_check = 1'b0;

        $display("data errors %0d, assertion failures %0d", errors, uut.u_chk.fail_cnt);
        if (errors == 0 && uut.u_chk.fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verif/cpu_mem_assertions.sv
`timescale 1ns/1ns

module cpu_mem_assertions #(
    parameter int MAIN_LATENCY = 4,
    parameter int H_TOTAL      = 24,
    parameter int H_SYNC       = 4,
    parameter int V_SYNC       = 2
) (
    input logic        pixel_clk,
    input logic        rst,
    input logic        dmem_read,
    input logic        dmem_write,
    input logic [29:0] dmem_addr,
    input logic        mem_stall,
    input logic [31:0] dmem_data_out,
    input logic        main_read,
    input logic        main_write,
    input logic        main_stall,
    input logic        vmem_wen,
    input logic        vga_hs,
    input logic        vga_vs
);
    int   fail_cnt = 0;
    int   stall_run;
    int   hs_low;
    int   vs_low;
    int   since_fall;
    logic loader_rd;
    logic vmem_req;
    logic reserved_rd;

    assign loader_rd   = dmem_read && (dmem_addr[29:26] == 4'hf);
    assign vmem_req    = dmem_write && (dmem_addr[29:26] == 4'hc);
    assign reserved_rd = dmem_read && (dmem_addr[29:26] inside {4'hd, 4'he});

    ////////////////////
    // run counters
    ////////////////////

    always_ff @(posedge pixel_clk) begin
        if (!rst) begin
            stall_run  <= 0;
            hs_low     <= 0;
            vs_low     <= 0;
            since_fall <= 0;
        end else begin
            stall_run <= main_stall ? stall_run + 1 : 0;
            hs_low    <= vga_hs ? 0 : hs_low + 1;
            vs_low    <= vga_vs ? 0 : vs_low + 1;
            // counts from one hsync fall to the next
            if ($fell(vga_hs)) begin
                since_fall <= 1;
            end else if (since_fall != 0) begin
                since_fall <= since_fall + 1;
            end
        end
    end

    ////////////////////
    // memory timing
    ////////////////////

    main_read_latency: assert property (@(posedge pixel_clk) disable iff (!rst)
        main_read && !main_stall |-> stall_run == MAIN_LATENCY)
        else begin $error("main read stall length %0d", stall_run); fail_cnt++; end

    main_write_no_stall: assert property (@(posedge pixel_clk) disable iff (!rst)
        main_write |-> !mem_stall)
        else begin $error("main write stalled"); fail_cnt++; end

    // loader read waits a single cycle
    loader_one_stall: assert property (@(posedge pixel_clk) disable iff (!rst)
        loader_rd && mem_stall |=> loader_rd && !mem_stall)
        else begin $error("loader read stall too long"); fail_cnt++; end

    loader_stalled_first: assert property (@(posedge pixel_clk) disable iff (!rst)
        loader_rd && !mem_stall |-> $past(mem_stall))
        else begin $error("loader read did not stall"); fail_cnt++; end

    // three stalls, pulses in cycles two and three
    vmem_sequence: assert property (@(posedge pixel_clk) disable iff (!rst)
        vmem_req && !$past(vmem_req) |-> mem_stall && !vmem_wen
        ##1 mem_stall && vmem_wen ##1 mem_stall && vmem_wen ##1 !mem_stall && !vmem_wen)
        else begin $error("video write sequence wrong"); fail_cnt++; end

    reserved_zero: assert property (@(posedge pixel_clk) disable iff (!rst)
        reserved_rd |-> !mem_stall && dmem_data_out == 32'h0)
        else begin $error("timer or keyboard read not zero"); fail_cnt++; end

    ////////////////////
    // sync timing
    ////////////////////

    hsync_width: assert property (@(posedge pixel_clk) disable iff (!rst)
        $rose(vga_hs) |-> hs_low == H_SYNC)
        else begin $error("hsync width %0d", hs_low); fail_cnt++; end

    hsync_period: assert property (@(posedge pixel_clk) disable iff (!rst)
        $fell(vga_hs) && since_fall != 0 |-> since_fall == H_TOTAL)
        else begin $error("line length %0d", since_fall); fail_cnt++; end

    vsync_width: assert property (@(posedge pixel_clk) disable iff (!rst)
        $rose(vga_vs) |-> vs_low == V_SYNC * H_TOTAL)
        else begin $error("vsync width %0d", vs_low); fail_cnt++; end

endmodule

bind cpu_mem_top cpu_mem_assertions #(
    .MAIN_LATENCY (MAIN_LATENCY),
    .H_TOTAL      (H_ACTIVE + H_FRONT + H_SYNC + H_BACK),
    .H_SYNC       (H_SYNC),
    .V_SYNC       (V_SYNC)
) u_chk (.*);

// File: verilog/cpu_mem_top.sv
`timescale 1ns/1ns

module cpu_mem_top #(
    parameter int MAIN_DEPTH_LOG2   = 12,
    parameter int LOADER_DEPTH_LOG2 = 10,
    parameter int MAIN_LATENCY      = 4,
    parameter int VMEM_ADDR_WIDTH   = 15,
    parameter int H_ACTIVE          = 640,
    parameter int H_FRONT           = 16,
    parameter int H_SYNC            = 96,
    parameter int H_BACK            = 48,
    parameter int V_ACTIVE          = 480,
    parameter int V_FRONT           = 10,
    parameter int V_SYNC            = 2,
    parameter int V_BACK            = 33
) (
    input  logic                               pixel_clk,
    input  logic                               rst,
    input  logic [mem_map_pkg::ADDR_WIDTH-1:0] instr_addr,
    input  logic                               dmem_read,
    input  logic                               dmem_write,
    input  logic [mem_map_pkg::ADDR_WIDTH-1:0] dmem_addr,
    input  logic [3:0]                         dmem_byte_en,
    input  logic [mem_map_pkg::DATA_WIDTH-1:0] data_from_reg,
    output logic                               mem_stall,
    output logic [mem_map_pkg::DATA_WIDTH-1:0] dmem_data_out,
    output logic [mem_map_pkg::DATA_WIDTH-1:0] instr_data_out,
    output logic [3:0]                         vga_r,
    output logic [3:0]                         vga_g,
    output logic [3:0]                         vga_b,
    output logic                               vga_hs,
    output logic                               vga_vs
);
    import mem_map_pkg::*;

    logic                       main_read;
    logic                       main_write;
    logic                       main_stall;
    logic [DATA_WIDTH-1:0]      main_rdata;
    logic [DATA_WIDTH-1:0]      main_instr;
    logic                       loader_write;
    logic                       loader_fetch;
    logic [ADDR_WIDTH-1:0]      loader_iaddr;
    logic [DATA_WIDTH-1:0]      loader_rdata;
    logic [DATA_WIDTH-1:0]      loader_instr;
    logic                       vmem_wen;
    logic [VMEM_ADDR_WIDTH-1:0] vmem_addr;
    logic [BYTE_LANE_W-1:0]     vmem_char;

    // loader fetch port parked at word 0 unless region 0xf is fetched
    assign loader_iaddr = loader_fetch ? instr_addr : '0;

    cpu_mem_interface #(
        .VMEM_ADDR_WIDTH (VMEM_ADDR_WIDTH)
    ) u_if (
        .pixel_clk      (pixel_clk),
        .rst            (rst),
        .instr_addr     (instr_addr),
        .dmem_read      (dmem_read),
        .dmem_write     (dmem_write),
        .dmem_addr      (dmem_addr),
        .dmem_byte_en   (dmem_byte_en),
        .data_from_reg  (data_from_reg),
        .main_stall     (main_stall),
        .main_rdata     (main_rdata),
        .loader_rdata   (loader_rdata),
        .loader_instr   (loader_instr),
        .main_instr     (main_instr),
        .mem_stall      (mem_stall),
        .dmem_data_out  (dmem_data_out),
        .instr_data_out (instr_data_out),
        .main_read      (main_read),
        .main_write     (main_write),
        .loader_write   (loader_write),
        .loader_fetch   (loader_fetch),
        .vmem_wen       (vmem_wen),
        .vmem_addr      (vmem_addr),
        .vmem_char      (vmem_char)
    );

    main_memory #(
        .MAIN_DEPTH_LOG2 (MAIN_DEPTH_LOG2),
        .MAIN_LATENCY    (MAIN_LATENCY)
    ) u_main (
        .pixel_clk  (pixel_clk),
        .rst        (rst),
        .main_read  (main_read),
        .main_write (main_write),
        .addr       (dmem_addr),
        .byte_en    (dmem_byte_en),
        .wdata      (data_from_reg),
        .instr_addr (instr_addr),
        .main_stall (main_stall),
        .main_rdata (main_rdata),
        .main_instr (main_instr)
    );

    loader_memory #(
        .LOADER_DEPTH_LOG2 (LOADER_DEPTH_LOG2)
    ) u_loader (
        .pixel_clk    (pixel_clk),
        .loader_write (loader_write),
        .data_addr    (dmem_addr),
        .wdata        (data_from_reg),
        .instr_addr   (loader_iaddr),
        .loader_rdata (loader_rdata),
        .loader_instr (loader_instr)
    );

    text_display #(
        .VMEM_ADDR_WIDTH (VMEM_ADDR_WIDTH),
        .H_ACTIVE        (H_ACTIVE),
        .H_FRONT         (H_FRONT),
        .H_SYNC          (H_SYNC),
        .H_BACK          (H_BACK),
        .V_ACTIVE        (V_ACTIVE),
        .V_FRONT         (V_FRONT),
        .V_SYNC          (V_SYNC),
        .V_BACK          (V_BACK)
    ) u_display (
        .pixel_clk (pixel_clk),
        .rst       (rst),
        .vmem_wen  (vmem_wen),
        .vmem_addr (vmem_addr),
        .vmem_char (vmem_char),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_hs    (vga_hs),
        .vga_vs    (vga_vs)
    );

endmodule

// File: verilog/text_display.sv
`timescale 1ns/1ns

module text_display #(
    parameter int VMEM_ADDR_WIDTH = 15,
    parameter int H_ACTIVE        = 640,
    parameter int H_FRONT         = 16,
    parameter int H_SYNC          = 96,
    parameter int H_BACK          = 48,
    parameter int V_ACTIVE        = 480,
    parameter int V_FRONT         = 10,
    parameter int V_SYNC          = 2,
    parameter int V_BACK          = 33
) (
    input  logic                                pixel_clk,
    input  logic                                rst,
    input  logic                                vmem_wen,
    input  logic [VMEM_ADDR_WIDTH-1:0]          vmem_addr,
    input  logic [mem_map_pkg::BYTE_LANE_W-1:0] vmem_char,
    output logic [3:0]                          vga_r,
    output logic [3:0]                          vga_g,
    output logic [3:0]                          vga_b,
    output logic                                vga_hs,
    output logic                                vga_vs
);
    import mem_map_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);
    localparam int COLS    = H_ACTIVE >> CELL_SHIFT;

    logic [BYTE_LANE_W-1:0]     text_buf [2**VMEM_ADDR_WIDTH];
    logic [HW-1:0]              h_cnt;
    logic [VW-1:0]              v_cnt;
    logic [VMEM_ADDR_WIDTH-1:0] cell_idx;
    logic                       active;
    logic                       hs_raw;
    logic                       vs_raw;
    logic [BYTE_LANE_W-1:0]     char_q;
    logic                       active_d1;
    logic                       hs_d1;
    logic                       vs_d1;

    ////////////////////
    // raster counters
    ////////////////////

    always_ff @(posedge pixel_clk) begin
        if (!rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == HW'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign active = (h_cnt < HW'(H_ACTIVE)) && (v_cnt < VW'(V_ACTIVE));
    // sync pulses sit after the front porch, active low
    assign hs_raw = !((h_cnt >= HW'(H_ACTIVE + H_FRONT)) &&
                      (h_cnt <  HW'(H_ACTIVE + H_FRONT + H_SYNC)));
    assign vs_raw = !((v_cnt >= VW'(V_ACTIVE + V_FRONT)) &&
                      (v_cnt <  VW'(V_ACTIVE + V_FRONT + V_SYNC)));

    // row of cells times columns plus cell column
    assign cell_idx = VMEM_ADDR_WIDTH'((v_cnt >> CELL_SHIFT) * COLS + (h_cnt >> CELL_SHIFT));

    ////////////////////
    // text buffer
    ////////////////////

    // stage 1 reads the code under the beam
    always_ff @(posedge pixel_clk) begin
        if (vmem_wen) begin
            text_buf[vmem_addr] <= vmem_char;
        end
        char_q <= text_buf[cell_idx];
    end

    // stage 2 turns the code into a color
    always_ff @(posedge pixel_clk) begin
        if (!rst) begin
            active_d1 <= 1'b0;
            hs_d1     <= 1'b1;
            vs_d1     <= 1'b1;
            vga_hs    <= 1'b1;
            vga_vs    <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            active_d1 <= active;
            hs_d1     <= hs_raw;
            vs_d1     <= vs_raw;
            vga_hs    <= hs_d1;
            vga_vs    <= vs_d1;
            // blank outside the visible window
            vga_r     <= active_d1 ? char_q[7:4] : 4'h0;
            vga_g     <= active_d1 ? char_q[3:0] : 4'h0;
            vga_b     <= active_d1 ? (char_q[7:4] ^ char_q[3:0]) : 4'h0;
        end
    end

endmodule

// File: verilog/loader_memory.sv
`timescale 1ns/1ns

module loader_memory #(
    parameter int LOADER_DEPTH_LOG2 = 10
) (
    input  logic                               pixel_clk,
    input  logic                               loader_write,
    input  logic [mem_map_pkg::ADDR_WIDTH-1:0] data_addr,
    input  logic [mem_map_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [mem_map_pkg::ADDR_WIDTH-1:0] instr_addr,
    output logic [mem_map_pkg::DATA_WIDTH-1:0] loader_rdata,
    output logic [mem_map_pkg::DATA_WIDTH-1:0] loader_instr
);
    import mem_map_pkg::*;

    logic [DATA_WIDTH-1:0]        mem [2**LOADER_DEPTH_LOG2];
    logic [LOADER_DEPTH_LOG2-1:0] a_idx;
    logic [LOADER_DEPTH_LOG2-1:0] b_idx;

    // only the low bits select a word inside region 0xf
    assign a_idx = data_addr[LOADER_DEPTH_LOG2-1:0];
    assign b_idx = instr_addr[LOADER_DEPTH_LOG2-1:0];

    ////////////////////
    // port a, data
    ////////////////////

    // whole word writes, byte enable ignored here
    always_ff @(posedge pixel_clk) begin
        if (loader_write) begin
            mem[a_idx] <= wdata;
        end
        loader_rdata <= mem[a_idx];
    end

    ////////////////////
    // port b, instr
    ////////////////////

    always_ff @(posedge pixel_clk) begin
        loader_instr <= mem[b_idx];
    end

endmodule

// File: verilog/main_memory.sv
`timescale 1ns/1ns

module main_memory #(
    parameter int MAIN_DEPTH_LOG2 = 12,
    parameter int MAIN_LATENCY    = 4
) (
    input  logic                               pixel_clk,
    input  logic                               rst,
    input  logic                               main_read,
    input  logic                               main_write,
    input  logic [mem_map_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [3:0]                         byte_en,
    input  logic [mem_map_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [mem_map_pkg::ADDR_WIDTH-1:0] instr_addr,
    output logic                               main_stall,
    output logic [mem_map_pkg::DATA_WIDTH-1:0] main_rdata,
    output logic [mem_map_pkg::DATA_WIDTH-1:0] main_instr
);
    import mem_map_pkg::*;

    localparam int CW = $clog2(MAIN_LATENCY + 1);

    logic [DATA_WIDTH-1:0]      mem [2**MAIN_DEPTH_LOG2];
    logic [MAIN_DEPTH_LOG2-1:0] d_idx;
    logic [MAIN_DEPTH_LOG2-1:0] i_idx;
    logic [CW-1:0]              lat_cnt;

    assign d_idx = addr[MAIN_DEPTH_LOG2-1:0];
    assign i_idx = instr_addr[MAIN_DEPTH_LOG2-1:0];

    // stall until the counter reaches the latency
    assign main_stall = main_read && (lat_cnt != CW'(MAIN_LATENCY));

    always_ff @(posedge pixel_clk) begin
        if (!rst || !main_read) begin
            lat_cnt <= '0;
        end else if (lat_cnt == CW'(MAIN_LATENCY)) begin
            // completing cycle, ready for a back to back read
            lat_cnt <= '0;
        end else begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    // byte writes, enable bit 3 covers bits 7:0
    always_ff @(posedge pixel_clk) begin
        if (main_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[3-i]) begin
                    mem[d_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
        if (main_read) begin
            main_rdata <= mem[d_idx];
        end
        // fetch port never waits
        main_instr <= mem[i_idx];
    end

endmodule

// File: verilog/cpu_mem_interface.sv
`timescale 1ns/1ns

module cpu_mem_interface #(
    parameter int VMEM_ADDR_WIDTH = 15
) (
    input  logic                                pixel_clk,
    input  logic                                rst,
    input  logic [mem_map_pkg::ADDR_WIDTH-1:0]  instr_addr,
    input  logic                                dmem_read,
    input  logic                                dmem_write,
    input  logic [mem_map_pkg::ADDR_WIDTH-1:0]  dmem_addr,
    input  logic [3:0]                          dmem_byte_en,
    input  logic [mem_map_pkg::DATA_WIDTH-1:0]  data_from_reg,
    input  logic                                main_stall,
    input  logic [mem_map_pkg::DATA_WIDTH-1:0]  main_rdata,
    input  logic [mem_map_pkg::DATA_WIDTH-1:0]  loader_rdata,
    input  logic [mem_map_pkg::DATA_WIDTH-1:0]  loader_instr,
    input  logic [mem_map_pkg::DATA_WIDTH-1:0]  main_instr,
    output logic                                mem_stall,
    output logic [mem_map_pkg::DATA_WIDTH-1:0]  dmem_data_out,
    output logic [mem_map_pkg::DATA_WIDTH-1:0]  instr_data_out,
    output logic                                main_read,
    output logic                                main_write,
    output logic                                loader_write,
    output logic                                loader_fetch,
    output logic                                vmem_wen,
    output logic [VMEM_ADDR_WIDTH-1:0]          vmem_addr,
    output logic [mem_map_pkg::BYTE_LANE_W-1:0] vmem_char
);
    import mem_map_pkg::*;

    region_e     data_region;
    vmem_state_e vw_state;
    logic        vmem_req;
    logic        loader_rd;
    logic        loader_hit;
    logic        fetch_loader_q;
    logic [1:0]  lane;

    // region from the top nibble of the word address
    function automatic region_e decode_region(input logic [ADDR_WIDTH-1:0] addr);
        case (addr[29:26])
            4'hc:    return REGION_VMEM;
            4'hd:    return REGION_TIMER;
            4'he:    return REGION_KBD;
            4'hf:    return REGION_LOADER;
            default: return REGION_MAIN;
        endcase
    endfunction

    ////////////////////
    // data steering
    ////////////////////

    assign data_region  = decode_region(dmem_addr);
    assign main_read    = dmem_read && (data_region == REGION_MAIN);
    assign main_write   = dmem_write && (data_region == REGION_MAIN);
    assign loader_write = dmem_write && (data_region == REGION_LOADER);
    assign loader_rd    = dmem_read && (data_region == REGION_LOADER);
    assign vmem_req     = dmem_write && (data_region == REGION_VMEM);

    // timer, keyboard and vmem reads all see zero
    always_comb begin
        case (data_region)
            REGION_MAIN:   dmem_data_out = main_rdata;
            REGION_LOADER: dmem_data_out = loader_rdata;
            default:       dmem_data_out = '0;
        endcase
    end

    // loader port is registered so a read waits one cycle
    always_ff @(posedge pixel_clk) begin
        if (!rst) begin
            loader_hit <= 1'b0;
        end else begin
            loader_hit <= loader_rd && !loader_hit;
        end
    end

    assign mem_stall = main_stall
                     | (loader_rd && !loader_hit)
                     | (vmem_req && (vw_state != VW_DONE));

    ////////////////////
    // video write
    ////////////////////

    // three stalled cycles, two write pulses, access completes in done
    always_ff @(posedge pixel_clk) begin
        if (!rst || !vmem_req) begin
            vw_state <= VW_IDLE;
        end else begin
            case (vw_state)
                VW_IDLE:   vw_state <= VW_FIRST;
                VW_FIRST:  vw_state <= VW_SECOND;
                VW_SECOND: vw_state <= VW_DONE;
                default:   vw_state <= VW_IDLE;
            endcase
        end
    end

    assign vmem_wen = (vw_state == VW_FIRST) || (vw_state == VW_SECOND);

    // one-hot enable to lane index, msb of enable is the low byte
    always_comb begin
        case (dmem_byte_en)
            4'b1000: lane = 2'd0;
            4'b0100: lane = 2'd1;
            4'b0010: lane = 2'd2;
            default: lane = 2'd3;
        endcase
    end

    assign vmem_addr = {dmem_addr[VMEM_ADDR_WIDTH-3:0], lane};
    assign vmem_char = data_from_reg[lane*BYTE_LANE_W +: BYTE_LANE_W];

    ////////////////////
    // instruction fetch
    ////////////////////

    assign loader_fetch = (decode_region(instr_addr) == REGION_LOADER);

    // both ports answer a cycle late, so pick by last cycle's region
    always_ff @(posedge pixel_clk) begin
        if (!rst) begin
            fetch_loader_q <= 1'b0;
        end else begin
            fetch_loader_q <= loader_fetch;
        end
    end

    assign instr_data_out = fetch_loader_q ? loader_instr : main_instr;

endmodule

// File: verilog/mem_map_pkg.sv
package mem_map_pkg;

    ////////////////////
    // bus widths
    ////////////////////

    // word address, byte lanes resolved by byte enable
    localparam int ADDR_WIDTH = 30;
    localparam int DATA_WIDTH = 32;

    // one character code per byte lane
    localparam int BYTE_LANE_W = 8;

    ////////////////////
    // address map
    ////////////////////

    // decoded from word address bits 29:26
    typedef enum logic [2:0] {
        REGION_MAIN,
        REGION_VMEM,
        REGION_TIMER,
        REGION_KBD,
        REGION_LOADER
    } region_e;

    // video write sequencer
    typedef enum logic [1:0] {
        VW_IDLE,
        VW_FIRST,
        VW_SECOND,
        VW_DONE
    } vmem_state_e;

    // 8x8 pixel text cells
    localparam int CELL_SHIFT = 3;

endpackage
